/* design/pcie_int_apb_regs.sv */
`include "pcie_int_macros.svh"

module pcie_int_apb_regs (
    input  logic                   apb_clk,
    input  logic                   apb_pcie_rst,
    input  pcie_int_pkg::apb_req_t  apb,
    output pcie_int_pkg::apb_data_t prdata,
    input  pcie_int_pkg::int_vec_t  status,
    input  pcie_int_pkg::int_vec_t  enable,
    output pcie_int_pkg::reg_wr_t   wr,
    output logic                   redo
);

    logic                   access;     // completing cycle, no wait states
    logic                   wr_access;
    logic                   clr_strobe_q;
    logic                   en_strobe_q;
    pcie_int_pkg::int_vec_t clr_mask_q;
    pcie_int_pkg::int_vec_t en_value_q;
    pcie_int_pkg::int_vec_t wdata_vec;

    assign access    = apb.psel && apb.penable;
    assign wr_access = access && apb.pwrite;
    assign wdata_vec = apb.pwdata[`PCIE_INT_NUM_SRC-1:0];

    // write strobes
    always_ff @(posedge apb_clk) begin
        if (apb_pcie_rst) begin
            clr_strobe_q <= 1'b0;
            en_strobe_q  <= 1'b0;
        end else begin
            clr_strobe_q <= wr_access && (apb.paddr == `PCIE_INT_REG_STATUS);
            en_strobe_q  <= wr_access && (apb.paddr == `PCIE_INT_REG_ENABLE);
        end
    end

    // write data travels beside the strobes
    always_ff @(posedge apb_clk) begin
        clr_mask_q <= wdata_vec;
        en_value_q <= wdata_vec;
    end

    assign wr.clr_strobe = clr_strobe_q;
    assign wr.clr_mask   = clr_mask_q;
    assign wr.en_strobe  = en_strobe_q;
    assign wr.en_value   = en_value_q;

    // redo goes straight to the controller latch, sets it on the access edge
    assign redo = wr_access && (apb.paddr == `PCIE_INT_REG_CTRL) && apb.pwdata[0];

    // read mux
    always_comb begin
        prdata = '0;
        case (apb.paddr)
            `PCIE_INT_REG_STATUS: begin
                prdata[`PCIE_INT_NUM_SRC-1:0] = status;
            end
            `PCIE_INT_REG_ENABLE: begin
                prdata[`PCIE_INT_NUM_SRC-1:0] = enable;
            end
            `PCIE_INT_REG_PENDING: begin
                prdata[`PCIE_INT_NUM_SRC-1:0] = status & enable;
            end
            default: begin
                prdata = '0;  // ctrl and unmapped read as zero
            end
        endcase
    end

endmodule

/* design/pcie_int_capture.sv */
module pcie_int_capture (
    input  logic                  apb_clk,
    input  logic                  apb_pcie_rst,
    input  pcie_int_pkg::int_vec_t src,
    input  pcie_int_pkg::reg_wr_t  wr,
    output pcie_int_pkg::int_vec_t status,
    output pcie_int_pkg::int_vec_t enable,
    output logic                  int_ob
);

    pcie_int_pkg::int_vec_t src_q;      // first sample of the source levels
    pcie_int_pkg::int_vec_t src_qq;     // previous value for edge detect
    pcie_int_pkg::int_vec_t src_rise;
    pcie_int_pkg::int_vec_t clr_bits;

    // two samples of the source levels
    always_ff @(posedge apb_clk) begin
        src_q  <= src;
        src_qq <= src_q;
    end

    assign src_rise = src_q & ~src_qq;
    assign clr_bits = wr.clr_strobe ? wr.clr_mask : '0;

    // sticky status
    // an edge in the same cycle as a clear wins
    always_ff @(posedge apb_clk) begin
        if (apb_pcie_rst) begin
            status <= '0;
        end else begin
            status <= (status & ~clr_bits) | src_rise;
        end
    end

    // enable mask
    always_ff @(posedge apb_clk) begin
        if (apb_pcie_rst) begin
            enable <= '0;
        end else if (wr.en_strobe) begin
            enable <= wr.en_value;
        end
    end

    // any enabled status bit asserts the outbound level
    assign int_ob = |(status & enable);

endmodule

/* design/pcie_int_ctrl.sv */
module pcie_int_ctrl (
    input  logic                      apb_clk,
    input  logic                      apb_pcie_rst,
    input  logic                      int_ob,
    input  logic                      redo,
    input  pcie_int_pkg::cfg_int_in_t  cfg_in,
    output pcie_int_pkg::cfg_int_out_t cfg_out
);

    pcie_int_pkg::int_state_e st;
    pcie_int_pkg::int_state_e next_st;
    logic                     redo_valid;   // redo latch
    logic                     redo_ready;
    logic                     interrupt_q;
    logic                     assert_q;

    // latch can only be consumed in idle, or dropped with msi off
    assign redo_ready = (st == pcie_int_pkg::st_idle) || !cfg_in.msienable;

    always_ff @(posedge apb_clk) begin
        if (apb_pcie_rst) begin
            redo_valid <= 1'b0;
        end else begin
            if (redo_ready) begin
                redo_valid <= 1'b0;
            end
            if (redo) begin
                redo_valid <= 1'b1;  // set beats clear
            end
        end
    end

    always_comb begin
        next_st = st;
        case (st)
            pcie_int_pkg::st_idle: begin
                if (int_ob) begin
                    if (cfg_in.msienable) begin
                        next_st = pcie_int_pkg::st_msi_set;
                    end else begin
                        next_st = pcie_int_pkg::st_legacy_set;
                    end
                end
            end
            pcie_int_pkg::st_msi_set: begin
                if (cfg_in.rdy) begin
                    next_st = pcie_int_pkg::st_msi_wait;
                end
            end
            pcie_int_pkg::st_msi_wait: begin
                // back to idle re-arms a new msi if int_ob is still high
                if (!int_ob || redo_valid) begin
                    next_st = pcie_int_pkg::st_idle;
                end
            end
            pcie_int_pkg::st_legacy_set: begin
                if (cfg_in.rdy) begin
                    next_st = pcie_int_pkg::st_legacy_wait;
                end
            end
            pcie_int_pkg::st_legacy_wait: begin
                if (!int_ob) begin
                    next_st = pcie_int_pkg::st_legacy_clear;
                end
            end
            pcie_int_pkg::st_legacy_clear: begin
                if (cfg_in.rdy) begin
                    next_st = pcie_int_pkg::st_idle;
                end
            end
            default: begin
                next_st = pcie_int_pkg::st_idle;
            end
        endcase
    end

    // core outputs registered from the next state
    always_ff @(posedge apb_clk) begin
        if (apb_pcie_rst) begin
            st          <= pcie_int_pkg::st_idle;
            interrupt_q <= 1'b0;
            assert_q    <= 1'b0;
        end else begin
            st          <= next_st;
            interrupt_q <= (next_st == pcie_int_pkg::st_msi_set)
                        || (next_st == pcie_int_pkg::st_legacy_set)
                        || (next_st == pcie_int_pkg::st_legacy_clear);
            assert_q    <= (next_st == pcie_int_pkg::st_legacy_set);  // high only for intx assert
        end
    end

    assign cfg_out.interrupt    = interrupt_q;
    assign cfg_out.assert_level = assert_q;

endmodule

/* design/pcie_int_macros.svh */
`ifndef PCIE_INT_MACROS_SVH
`define PCIE_INT_MACROS_SVH

// interrupt sources feeding the sticky status register
`define PCIE_INT_NUM_SRC 8

// apb address bus
`define PCIE_INT_APB_AW 12

// register map, byte offsets

// sticky status, write one to clear
`define PCIE_INT_REG_STATUS 12'h000

// per-source enable mask
`define PCIE_INT_REG_ENABLE 12'h004

// status and enable, read only
`define PCIE_INT_REG_PENDING 12'h008

// bit 0 written high re-sends an active msi
`define PCIE_INT_REG_CTRL 12'h00C

`endif

/* design/pcie_int_pkg.sv */
`include "pcie_int_macros.svh"

package pcie_int_pkg;

    typedef logic [`PCIE_INT_NUM_SRC-1:0] int_vec_t;  // one bit per source
    typedef logic [`PCIE_INT_APB_AW-1:0]  apb_addr_t;
    typedef logic [31:0]                  apb_data_t;

    // apb request from the master
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // register writes towards the capture block
    typedef struct packed {
        logic     clr_strobe;   // single cycle
        int_vec_t clr_mask;
        logic     en_strobe;    // single cycle
        int_vec_t en_value;
    } reg_wr_t;

    // endpoint core interrupt interface
    typedef struct packed {
        logic msienable;
        logic rdy;
    } cfg_int_in_t;

    typedef struct packed {
        logic interrupt;
        logic assert_level;  // legacy only, 1 = assert, 0 = deassert
    } cfg_int_out_t;

    typedef enum logic [2:0] {
        st_idle,          // wait for int_ob
        st_msi_set,       // msi request to core
        st_msi_wait,      // wait for int_ob to drop or a redo
        st_legacy_set,    // intx assert to core
        st_legacy_wait,   // wait for int_ob to drop
        st_legacy_clear   // intx deassert to core
    } int_state_e;

endpackage

/* design/pcie_int_top.sv */
module pcie_int_top (
    input  logic                      apb_clk,
    input  logic                      apb_pcie_rst,
    input  pcie_int_pkg::apb_req_t     apb,
    output pcie_int_pkg::apb_data_t    prdata,
    input  pcie_int_pkg::int_vec_t     src,
    input  pcie_int_pkg::cfg_int_in_t  cfg_in,
    output pcie_int_pkg::cfg_int_out_t cfg_out
);

    pcie_int_pkg::reg_wr_t  wr;       // status clear and enable writes
    pcie_int_pkg::int_vec_t status;
    pcie_int_pkg::int_vec_t enable;
    logic                   redo;
    logic                   int_ob;   // outbound interrupt level

    // apb register decode
    pcie_int_apb_regs u_apb_regs (
        .apb_clk      (apb_clk),
        .apb_pcie_rst (apb_pcie_rst),
        .apb          (apb),
        .prdata       (prdata),
        .status       (status),
        .enable       (enable),
        .wr           (wr),
        .redo         (redo)
    );

    // source edges into sticky status
    pcie_int_capture u_capture (
        .apb_clk      (apb_clk),
        .apb_pcie_rst (apb_pcie_rst),
        .src          (src),
        .wr           (wr),
        .status       (status),
        .enable       (enable),
        .int_ob       (int_ob)
    );

    // msi and intx sequencing towards the core
    pcie_int_ctrl u_ctrl (
        .apb_clk      (apb_clk),
        .apb_pcie_rst (apb_pcie_rst),
        .int_ob       (int_ob),
        .redo         (redo),
        .cfg_in       (cfg_in),
        .cfg_out      (cfg_out)
    );

endmodule

/* project.f */
+incdir+design
design/pcie_int_pkg.sv
design/pcie_int_capture.sv
design/pcie_int_apb_regs.sv
design/pcie_int_ctrl.sv
design/pcie_int_top.sv
test/pcie_int_properties.sv
test/pcie_int_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --assert --timescale 1ns/1ps --top-module pcie_int_tb \
        -f project.f -o pcie_int_sim \
    && ./obj_dir/pcie_int_sim \
    || exit 1

/* test/pcie_int_properties.sv */
module pcie_int_properties (
    input logic                       apb_clk,
    input logic                       apb_pcie_rst,
    input pcie_int_pkg::cfg_int_in_t  cfg_in,
    input pcie_int_pkg::cfg_int_out_t cfg_out
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;  // polled by the testbench

    // request held with a constant level until rdy
    a_hold: assert property (@(posedge apb_clk) disable iff (apb_pcie_rst)
        cfg_out.interrupt && !cfg_in.rdy |=> cfg_out.interrupt && $stable(cfg_out.assert_level))
        else begin
            fail_cnt++;
            $error("interrupt request dropped or changed level before rdy");
        end

    a_drop: assert property (@(posedge apb_clk) disable iff (apb_pcie_rst)
        cfg_out.interrupt && cfg_in.rdy |=> !cfg_out.interrupt)
        else begin
            fail_cnt++;
            $error("interrupt still high the cycle after rdy");
        end

    a_reset: assert property (@(posedge apb_clk)
        apb_pcie_rst |=> !cfg_out.interrupt && !cfg_out.assert_level)
        else begin
            fail_cnt++;
            $error("core interrupt outputs not low during reset");
        end

endmodule

bind pcie_int_top pcie_int_properties u_props (
    .apb_clk      (apb_clk),
    .apb_pcie_rst (apb_pcie_rst),
    .cfg_in       (cfg_in),
    .cfg_out      (cfg_out)
);

/* test/pcie_int_tb.sv */
`include "pcie_int_macros.svh"

module pcie_int_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                       apb_clk = 1'b0;
    logic                       apb_pcie_rst;
    pcie_int_pkg::apb_req_t     apb;
    pcie_int_pkg::apb_data_t    prdata;
    pcie_int_pkg::int_vec_t     src;
    pcie_int_pkg::cfg_int_in_t  cfg_in;
    pcie_int_pkg::cfg_int_out_t cfg_out;
    logic                       msienable;
    logic                       rdy = 1'b0;
    logic                       rdy_hold;           // endpoint stalls while set
    logic                       rdy_armed = 1'b0;
    logic [1:0]                 rdy_delay = 2'd0;
    logic [15:0]                lfsr = 16'd28099;
    pcie_int_pkg::int_vec_t     exp_status;         // model of the sticky bits
    pcie_int_pkg::int_vec_t     exp_enable;

    assign cfg_in.msienable = msienable;
    assign cfg_in.rdy       = rdy;

    pcie_int_top DUT (.*);

    always #20 apb_clk = ~apb_clk;

    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    // endpoint core answers a request after 0 to 3 cycles
    always @(negedge apb_clk) begin
        if (apb_pcie_rst || rdy || rdy_hold || !cfg_out.interrupt) begin
            rdy       = 1'b0;
            rdy_armed = 1'b0;
        end else if (!rdy_armed) begin
            for (int i = 0; i < 2; i++) begin
                lfsr         = lfsr_next(lfsr);  // one step per delay bit
                rdy_delay[i] = lfsr[0];
            end
            rdy_armed = 1'b1;
            rdy       = (rdy_delay == 2'd0);
        end else begin
            rdy_delay = rdy_delay - 2'd1;
            rdy       = (rdy_delay == 2'd0);
        end
    end

    always @(negedge apb_clk) begin
        if (DUT.u_props.fail_cnt != 0) begin
            $display("an assertion on the core interrupt interface failed");
            stop_on_error();
        end
    end

    // one access without wait states
    task automatic apb_access(input logic write, input pcie_int_pkg::apb_addr_t addr,
                              input pcie_int_pkg::apb_data_t wdata,
                              output pcie_int_pkg::apb_data_t rdata);
        apb = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(negedge apb_clk);
        apb.penable = 1'b1;
        rdata = prdata;  // stable through the access cycle
        @(posedge apb_clk);
        @(negedge apb_clk);
        apb = '0;
    endtask

    task automatic write_reg(input pcie_int_pkg::apb_addr_t addr,
                             input pcie_int_pkg::apb_data_t data);
        pcie_int_pkg::apb_data_t unused;
        if (addr == `PCIE_INT_REG_STATUS) begin
            exp_status = exp_status & ~data[`PCIE_INT_NUM_SRC-1:0];  // write one to clear
        end
        if (addr == `PCIE_INT_REG_ENABLE) begin
            exp_enable = data[`PCIE_INT_NUM_SRC-1:0];
        end
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic check_reg(input string name, input pcie_int_pkg::apb_addr_t addr,
                             input pcie_int_pkg::int_vec_t expected);
        pcie_int_pkg::apb_data_t data;
        apb_access(1'b0, addr, '0, data);
        assert (data == pcie_int_pkg::apb_data_t'(expected)) else begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, data);
            stop_on_error();
        end
    endtask

    // whole register map against the model
    task automatic check_regs();
        check_reg("STATUS", `PCIE_INT_REG_STATUS, exp_status);
        check_reg("ENABLE", `PCIE_INT_REG_ENABLE, exp_enable);
        check_reg("PENDING", `PCIE_INT_REG_PENDING, exp_status & exp_enable);
    endtask

    // a rising level reaches status after 2 cycles
    task automatic set_src(input int idx, input logic level);
        if (level && !src[idx]) begin
            exp_status[idx] = 1'b1;
        end
        src[idx] = level;
        repeat (2) @(negedge apb_clk);
    endtask

    task automatic wait_interrupt(input logic value, input string what);
        int cycles;
        cycles = 0;
        while (cfg_out.interrupt != value && cycles < 64) begin
            @(negedge apb_clk);
            cycles++;
        end
        if (cfg_out.interrupt != value) begin
            $display("timeout while waiting for %s", what);
            stop_on_error();
        end
    endtask

    // one request and its level until rdy ends it
    task automatic serve_request(input logic level);
        wait_interrupt(1'b1, "an interrupt request to the core");
        assert (cfg_out.assert_level == level) else begin
            $display("Mismatch at %0t: cfg_out.assert_level expected %b, got %b",
                     $time, level, cfg_out.assert_level);
            stop_on_error();
        end
        wait_interrupt(1'b0, "the core to accept the request");
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge apb_clk);
            assert (cfg_out == '0) else begin
                $display("Mismatch at %0t: cfg_out expected 00, got %b", $time, cfg_out);
                stop_on_error();
            end
        end
    endtask

    initial begin
        apb_pcie_rst = 1'b1;
        apb          = '0;
        src          = '0;
        msienable    = 1'b0;
        rdy_hold     = 1'b0;
        exp_status   = '0;
        exp_enable   = '0;
        repeat (8) @(negedge apb_clk);
        apb_pcie_rst = 1'b0;
        expect_quiet(1);
        check_regs();

        // masked source sets status only
        set_src(2, 1'b1);
        check_regs();
        expect_quiet(4);

        // legacy intx assert and deassert once status is cleared
        write_reg(`PCIE_INT_REG_ENABLE, 32'h04);
        serve_request(1'b1);
        set_src(5, 1'b1);
        write_reg(`PCIE_INT_REG_STATUS, 32'h04);
        serve_request(1'b0);
        check_regs();

        // msi sends one message per assertion
        msienable = 1'b1;
        write_reg(`PCIE_INT_REG_ENABLE, 32'h02);
        set_src(1, 1'b1);
        serve_request(1'b0);
        expect_quiet(8);

        // redo while pending and then with nothing pending
        write_reg(`PCIE_INT_REG_CTRL, 32'h1);
        serve_request(1'b0);
        expect_quiet(8);
        write_reg(`PCIE_INT_REG_STATUS, 32'h02);
        check_regs();
        write_reg(`PCIE_INT_REG_CTRL, 32'h1);
        expect_quiet(8);

        // stalled endpoint where new edges only land in status
        rdy_hold = 1'b1;
        write_reg(`PCIE_INT_REG_ENABLE, 32'h01);
        set_src(0, 1'b1);
        set_src(3, 1'b1);
        check_regs();
        assert (cfg_out.interrupt) else begin
            $display("Mismatch at %0t: cfg_out.interrupt expected 1, got %b",
                     $time, cfg_out.interrupt);
            stop_on_error();
        end
        rdy_hold = 1'b0;
        serve_request(1'b0);

        // repeated msi with random endpoint latency
        for (int round = 0; round < 4; round++) begin
            write_reg(`PCIE_INT_REG_STATUS, 32'h01);
            set_src(0, 1'b0);
            set_src(0, 1'b1);
            serve_request(1'b0);
        end
        check_regs();

        $display("Testbench passed");
        $finish;
    end

endmodule
